// ==== src.f ====
+incdir+source
+incdir+test
source/mmu_pkg.sv
source/dtlb.sv
source/lookup_stage_reg.sv
source/access_check.sv
source/dmmu.sv
test/tb_dmmu.sv

// ==== Bender.yml ====
package:
  name: dmmu

sources:
  - include_dirs:
      - source
    files:
      - source/mmu_pkg.sv
      - source/dtlb.sv
      - source/lookup_stage_reg.sv
      - source/access_check.sv
      - source/dmmu.sv
  - target: test
    include_dirs:
      - source
      - test
    files:
      - test/tb_dmmu.sv

// ==== test/tb_dmmu_vectors.svh ====
`ifndef TB_DMMU_VECTORS_SVH
`define TB_DMMU_VECTORS_SVH

// one table row per step
// unused fields of a row stay X and are never driven
typedef enum {OP_REFILL, OP_FLUSH, OP_REQ} op_t;

typedef struct {
    string          name;
    op_t            op;
    logic [38:0]    va;
    logic [8:0]     asid;
    logic           is_store;
    logic           en;
    priv_lvl_t      priv;
    logic           sum;
    logic           is_2m;
    logic           is_1g;
    logic [43:0]    ppn;
    logic [7:0]     flags;
    logic [55:0]    exp_paddr;
    logic           exp_miss;
    logic           exp_exc;
    logic [5:0]     exp_cause;
} vec_t;

vec_t vecs[$];

// pte flag bytes in the order {d, a, g, u, x, w, r, v}
localparam logic [7:0] PTE_RW    = 8'hc7;
localparam logic [7:0] PTE_RO    = 8'hc3;
localparam logic [7:0] PTE_RW_G  = 8'he7;
localparam logic [7:0] PTE_RW_U  = 8'hd7;
localparam logic [7:0] PTE_CLEAN = 8'h47;

function automatic void add_refill(input string name, input logic [38:0] va,
                                   input logic [8:0] asid, input logic is_2m,
                                   input logic is_1g, input logic [43:0] ppn,
                                   input logic [7:0] flags);
    vec_t v;
    v.name  = name;
    v.op    = OP_REFILL;
    v.va    = va;
    v.asid  = asid;
    v.is_2m = is_2m;
    v.is_1g = is_1g;
    v.ppn   = ppn;
    v.flags = flags;
    vecs.push_back(v);
endfunction

function automatic void add_flush(input string name, input logic [8:0] asid,
                                  input logic [38:0] va);
    vec_t v;
    v.name = name;
    v.op   = OP_FLUSH;
    v.asid = asid;
    v.va   = va;
    vecs.push_back(v);
endfunction

// cause 0 means no exception expected
function automatic void add_req(input string name, input logic [38:0] va,
                                input logic [8:0] asid, input logic st, input priv_lvl_t priv,
                                input logic sum, input logic [55:0] paddr, input logic miss,
                                input int cause);
    vec_t v;
    v.name      = name;
    v.op        = OP_REQ;
    v.va        = va;
    v.asid      = asid;
    v.is_store  = st;
    v.en        = 1'b1;
    v.priv      = priv;
    v.sum       = sum;
    v.exp_paddr = paddr;
    v.exp_miss  = miss;
    v.exp_exc   = (cause != 0);
    v.exp_cause = cause[5:0];
    vecs.push_back(v);
endfunction

function automatic void add_bare(input string name, input logic [38:0] va,
                                 input logic [55:0] paddr);
    add_req(name, va, 9'd0, 1'b0, PRIV_S, 1'b0, paddr, 1'b0, 0);
    vecs[vecs.size() - 1].en = 1'b0;
endfunction

// ----------------------------------------------------------------------
// the table
// ----------------------------------------------------------------------

// round robin puts A B C D into slots 0 to 3
// then the clean page lands over A and the user page over B
function automatic void build_table();
    add_bare("bare_load", 39'h12_3456_789a, 56'h12_3456_789a);
    // 4K page A, vpn 1/2/3
    add_req("miss_empty", 39'h00_4040_3456, 9'd1, 0, PRIV_S, 0, 56'h0, 1, 0);
    add_refill("fill_4k", 39'h00_4040_3000, 9'd1, 0, 0, 44'habcde, PTE_RW);
    add_req("hit_4k_load", 39'h00_4040_3456, 9'd1, 0, PRIV_S, 0, 56'hab_cde456, 0, 0);
    add_req("hit_4k_store", 39'h00_4040_3456, 9'd1, 1, PRIV_S, 0, 56'hab_cde456, 0, 0);
    add_req("miss_other_asid", 39'h00_4040_3456, 9'd2, 0, PRIV_S, 0, 56'h0, 1, 0);
    // 2M page B keeps vpn0 from the request
    add_refill("fill_2m", 39'h00_80a0_0000, 9'd1, 1, 0, 44'h12345, PTE_RW);
    add_req("hit_2m", 39'h00_80a1_f7c0, 9'd1, 0, PRIV_S, 0, 56'h12_21f7c0, 0, 0);
    // 1G global page C of asid 1 looked up under asid 5
    add_refill("fill_1g_global", 39'h00_c000_0000, 9'd1, 0, 1, 44'h40000, PTE_RW_G);
    add_req("hit_1g_global", 39'h00_c222_2333, 9'd5, 0, PRIV_S, 0, 56'h42_222333, 0, 0);
    // read only supervisor page D
    add_refill("fill_ro", 39'h01_0000_1000, 9'd1, 0, 0, 44'h111, PTE_RO);
    add_req("ro_store", 39'h01_0000_1010, 9'd1, 1, PRIV_S, 0, 56'h11_1010, 0, 15);
    add_req("ro_load", 39'h01_0000_1010, 9'd1, 0, PRIV_S, 0, 56'h11_1010, 0, 0);
    add_req("u_load_super", 39'h01_0000_1010, 9'd1, 0, PRIV_U, 0, 56'h11_1010, 0, 13);
    add_req("u_store_super", 39'h01_0000_1010, 9'd1, 1, PRIV_U, 0, 56'h11_1010, 0, 15);
    // writable page that is not dirty
    add_refill("fill_clean", 39'h01_4000_2000, 9'd1, 0, 0, 44'h222, PTE_CLEAN);
    add_req("clean_store", 39'h01_4000_2020, 9'd1, 1, PRIV_S, 0, 56'h22_2020, 0, 15);
    add_req("clean_load", 39'h01_4000_2020, 9'd1, 0, PRIV_S, 0, 56'h22_2020, 0, 0);
    add_req("evicted_4k", 39'h00_4040_3456, 9'd1, 0, PRIV_S, 0, 56'h0, 1, 0);
    // user page F in the upper half, its tval carries the sign
    add_refill("fill_user", 39'h41_8020_0000, 9'd1, 0, 0, 44'h333, PTE_RW_U);
    add_req("s_user_no_sum", 39'h41_8020_0044, 9'd1, 0, PRIV_S, 0, 56'h33_3044, 0, 13);
    add_req("s_user_st_no_sum", 39'h41_8020_0044, 9'd1, 1, PRIV_S, 0, 56'h33_3044, 0, 15);
    add_req("s_user_sum", 39'h41_8020_0044, 9'd1, 0, PRIV_S, 1, 56'h33_3044, 0, 0);
    add_req("u_store_user", 39'h41_8020_0044, 9'd1, 1, PRIV_U, 0, 56'h33_3044, 0, 0);
    // asid flush keeps only the global page
    add_flush("flush_asid1", 9'd1, 39'h0);
    add_req("flushed_user", 39'h41_8020_0044, 9'd1, 0, PRIV_U, 0, 56'h0, 1, 0);
    add_req("flushed_ro", 39'h01_0000_1010, 9'd1, 0, PRIV_S, 0, 56'h0, 1, 0);
    add_req("global_kept", 39'h00_c222_2333, 9'd5, 0, PRIV_S, 0, 56'h42_222333, 0, 0);
    add_flush("flush_all", 9'd0, 39'h0);
    add_req("flushed_global", 39'h00_c222_2333, 9'd5, 0, PRIV_S, 0, 56'h0, 1, 0);
endfunction

`endif

// ==== test/tb_dmmu.sv ====
`timescale 1ns/1ps
`include "mmu_settings.svh"

module tb_dmmu;
    import mmu_pkg::*;

    localparam int CLK_PERIOD = 100;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   req_valid_i;
    logic                   req_ready_o;
    vaddr_t                 req_vaddr_i;
    logic                   req_is_store_i;
    logic                   en_translation_i;
    priv_lvl_t              priv_lvl_i;
    logic                   sum_i;
    logic [`MMU_ASIDW-1:0]  asid_i;
    logic                   resp_valid_o;
    logic                   resp_ready_i;
    logic [`MMU_PLEN-1:0]   resp_paddr_o;
    logic                   resp_miss_o;
    logic                   exc_valid_o;
    exc_cause_t             exc_cause_o;
    logic [`MMU_XLEN-1:0]   exc_tval_o;
    logic                   upd_valid_i;
    vaddr_t                 upd_vaddr_i;
    logic [`MMU_ASIDW-1:0]  upd_asid_i;
    logic                   upd_is_2m_i;
    logic                   upd_is_1g_i;
    pte_t                   upd_pte_i;
    logic                   flush_i;
    logic [`MMU_ASIDW-1:0]  flush_asid_i;
    vaddr_t                 flush_vaddr_i;

    int     errors;
    int     checks;
    int     req_count;
    int     resp_count;
    integer seed;
    logic   table_ready;

    `include "tb_dmmu_vectors.svh"

    dmmu dmmu_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // random back-pressure, ready about three cycles in four
    always @(posedge clk_i) begin
        resp_ready_i <= (($random(seed) & 3) != 0);
    end

    // count completed responses, sampled mid cycle
    always @(negedge clk_i) begin
        if (rst_ni && resp_valid_o && resp_ready_i) begin
            resp_count++;
        end
    end

    // ----------------------------------------------------------------------
    // check and drive tasks
    // ----------------------------------------------------------------------

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s %s: expected %h actual %h", name, what, expected, actual);
        end
    endtask

    // tval is the sign extended virtual address
    task automatic compare_response(input vec_t v);
        check_value(v.name, "miss", v.exp_miss, resp_miss_o);
        check_value(v.name, "exc_valid", v.exp_exc, exc_valid_o);
        if (!v.exp_miss) begin
            check_value(v.name, "paddr", v.exp_paddr, resp_paddr_o);
        end
        if (v.exp_exc) begin
            check_value(v.name, "cause", v.exp_cause, exc_cause_o);
            check_value(v.name, "tval", {{25{v.va[38]}}, v.va}, exc_tval_o);
        end
    endtask

    task automatic apply_refill(input vec_t v);
        @(posedge clk_i);
        upd_valid_i <= 1'b1;
        upd_vaddr_i <= v.va;
        upd_asid_i  <= v.asid;
        upd_is_2m_i <= v.is_2m;
        upd_is_1g_i <= v.is_1g;
        upd_pte_i   <= {v.ppn, v.flags};
        @(posedge clk_i);
        upd_valid_i <= 1'b0;
    endtask

    task automatic apply_flush(input vec_t v);
        @(posedge clk_i);
        flush_i       <= 1'b1;
        flush_asid_i  <= v.asid;
        flush_vaddr_i <= v.va;
        @(posedge clk_i);
        flush_i <= 1'b0;
    endtask

    task automatic apply_request(input vec_t v);
        logic done;
        @(posedge clk_i);
        req_valid_i      <= 1'b1;
        req_vaddr_i      <= v.va;
        req_is_store_i   <= v.is_store;
        en_translation_i <= v.en;
        priv_lvl_i       <= v.priv;
        sum_i            <= v.sum;
        asid_i           <= v.asid;
        // accepted at the edge after a cycle with ready high
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        req_count++;
        @(negedge clk_i);
        while (!resp_valid_o) begin
            @(negedge clk_i);
        end
        // compared in every stalled cycle too, payload must not move
        done = 1'b0;
        while (!done) begin
            compare_response(v);
            done = resp_ready_i;
            if (!done) begin
                @(negedge clk_i);
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin : main
        errors           = 0;
        checks           = 0;
        req_count        = 0;
        resp_count       = 0;
        seed             = 32'h3bfb_4d9e;
        table_ready      = 1'b0;
        rst_ni           = 1'b0;
        req_valid_i      = 1'b0;
        req_vaddr_i      = '0;
        req_is_store_i   = 1'b0;
        en_translation_i = 1'b0;
        priv_lvl_i       = PRIV_S;
        sum_i            = 1'b0;
        asid_i           = '0;
        resp_ready_i     = 1'b0;
        upd_valid_i      = 1'b0;
        upd_vaddr_i      = '0;
        upd_asid_i       = '0;
        upd_is_2m_i      = 1'b0;
        upd_is_1g_i      = 1'b0;
        upd_pte_i        = '0;
        flush_i          = 1'b0;
        flush_asid_i     = '0;
        flush_vaddr_i    = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("reset", "req_ready", 1'b1, req_ready_o);
        check_value("reset", "resp_valid", 1'b0, resp_valid_o);
        check_value("reset", "exc_valid", 1'b0, exc_valid_o);
        foreach (vecs[i]) begin
            case (vecs[i].op)
                OP_REFILL: apply_refill(vecs[i]);
                OP_FLUSH:  apply_flush(vecs[i]);
                default:   apply_request(vecs[i]);
            endcase
        end
        // let the last response drain
        @(posedge clk_i);
        @(negedge clk_i);
        check_value("end", "responses", req_count, resp_count);
        check_value("end", "resp_valid", 1'b0, resp_valid_o);
        $display("tb_dmmu: %0d rows, %0d checks, %0d errors", vecs.size(), checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // twenty cycles per table row
    initial begin : watchdog
        wait (table_ready);
        #(vecs.size() * 20 * CLK_PERIOD);
        $display("watchdog: DUT stopped responding after %0d requests, %0d responses",
                 req_count, resp_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== source/dmmu.sv ====
`timescale 1ns/1ps
`include "mmu_settings.svh"

module dmmu (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // request side
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  mmu_pkg::vaddr_t         req_vaddr_i,
    input  logic                    req_is_store_i,
    input  logic                    en_translation_i,
    input  mmu_pkg::priv_lvl_t      priv_lvl_i,
    input  logic                    sum_i,
    input  logic [`MMU_ASIDW-1:0]   asid_i,
    // response side
    output logic                    resp_valid_o,
    input  logic                    resp_ready_i,
    output logic [`MMU_PLEN-1:0]    resp_paddr_o,
    output logic                    resp_miss_o,
    output logic                    exc_valid_o,
    output mmu_pkg::exc_cause_t     exc_cause_o,
    output logic [`MMU_XLEN-1:0]    exc_tval_o,
    // refill
    input  logic                    upd_valid_i,
    input  mmu_pkg::vaddr_t         upd_vaddr_i,
    input  logic [`MMU_ASIDW-1:0]   upd_asid_i,
    input  logic                    upd_is_2m_i,
    input  logic                    upd_is_1g_i,
    input  mmu_pkg::pte_t           upd_pte_i,
    // flush
    input  logic                    flush_i,
    input  logic [`MMU_ASIDW-1:0]   flush_asid_i,
    input  mmu_pkg::vaddr_t         flush_vaddr_i
);
    import mmu_pkg::*;

    // tlb answer in the request cycle
    logic       tlb_hit;
    pte_t       tlb_pte;
    logic       tlb_is_2m;
    logic       tlb_is_1g;

    // registered stage
    logic       s_valid;
    vaddr_t     s_vaddr;
    logic       s_is_store;
    logic       s_hit;
    pte_t       s_pte;
    logic       s_is_2m;
    logic       s_is_1g;
    logic       s_en_translation;
    priv_lvl_t  s_priv_lvl;
    logic       s_sum;

    // ------------------------------------------------------------------
    // cycle 0 lookup
    // ------------------------------------------------------------------

    dtlb #(
        .NumEntries    ( `MMU_TLB_ENTRIES )
    ) i_dtlb (
        .clk_i         ( clk_i            ),
        .rst_ni        ( rst_ni           ),
        .lu_vaddr_i    ( req_vaddr_i      ),
        .lu_asid_i     ( asid_i           ),
        .lu_hit_o      ( tlb_hit          ),
        .lu_pte_o      ( tlb_pte          ),
        .lu_is_2m_o    ( tlb_is_2m        ),
        .lu_is_1g_o    ( tlb_is_1g        ),
        .upd_valid_i   ( upd_valid_i      ),
        .upd_vaddr_i   ( upd_vaddr_i      ),
        .upd_asid_i    ( upd_asid_i       ),
        .upd_is_2m_i   ( upd_is_2m_i      ),
        .upd_is_1g_i   ( upd_is_1g_i      ),
        .upd_pte_i     ( upd_pte_i        ),
        .flush_i       ( flush_i          ),
        .flush_asid_i  ( flush_asid_i     ),
        .flush_vaddr_i ( flush_vaddr_i    )
    );

    lookup_stage_reg i_stage (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .in_valid_i       ( req_valid_i      ),
        .in_ready_o       ( req_ready_o      ),
        .out_valid_o      ( s_valid          ),
        .out_ready_i      ( resp_ready_i     ),
        .vaddr_i          ( req_vaddr_i      ),
        .is_store_i       ( req_is_store_i   ),
        .hit_i            ( tlb_hit          ),
        .pte_i            ( tlb_pte          ),
        .is_2m_i          ( tlb_is_2m        ),
        .is_1g_i          ( tlb_is_1g        ),
        .en_translation_i ( en_translation_i ),
        .priv_lvl_i       ( priv_lvl_i       ),
        .sum_i            ( sum_i            ),
        .vaddr_o          ( s_vaddr          ),
        .is_store_o       ( s_is_store       ),
        .hit_o            ( s_hit            ),
        .pte_o            ( s_pte            ),
        .is_2m_o          ( s_is_2m          ),
        .is_1g_o          ( s_is_1g          ),
        .en_translation_o ( s_en_translation ),
        .priv_lvl_o       ( s_priv_lvl       ),
        .sum_o            ( s_sum            )
    );

    // ------------------------------------------------------------------
    // cycle 1 response
    // ------------------------------------------------------------------

    assign resp_valid_o = s_valid;

    access_check i_check (
        .valid_i          ( s_valid          ),
        .vaddr_i          ( s_vaddr          ),
        .is_store_i       ( s_is_store       ),
        .hit_i            ( s_hit            ),
        .pte_i            ( s_pte            ),
        .is_2m_i          ( s_is_2m          ),
        .is_1g_i          ( s_is_1g          ),
        .en_translation_i ( s_en_translation ),
        .priv_lvl_i       ( s_priv_lvl       ),
        .sum_i            ( s_sum            ),
        .paddr_o          ( resp_paddr_o     ),
        .miss_o           ( resp_miss_o      ),
        .exc_valid_o      ( exc_valid_o      ),
        .exc_cause_o      ( exc_cause_o      ),
        .exc_tval_o       ( exc_tval_o       )
    );

endmodule

// ==== source/access_check.sv ====
`timescale 1ns/1ps
`include "mmu_settings.svh"

module access_check (
    input  logic                    valid_i,
    input  mmu_pkg::vaddr_t         vaddr_i,
    input  logic                    is_store_i,
    input  logic                    hit_i,
    input  mmu_pkg::pte_t           pte_i,
    input  logic                    is_2m_i,
    input  logic                    is_1g_i,
    input  logic                    en_translation_i,
    input  mmu_pkg::priv_lvl_t      priv_lvl_i,
    input  logic                    sum_i,
    output logic [`MMU_PLEN-1:0]    paddr_o,
    output logic                    miss_o,
    output logic                    exc_valid_o,
    output mmu_pkg::exc_cause_t     exc_cause_o,
    output logic [`MMU_XLEN-1:0]    exc_tval_o
);
    import mmu_pkg::*;

    logic s_mode;
    logic priv_err;
    logic fault;

    // ------------------------------------------------------------------
    // permission checks
    // ------------------------------------------------------------------

    // anything other than U counts as supervisor
    assign s_mode = (priv_lvl_i != PRIV_U);

    // user page from S without SUM, or supervisor page from U
    assign priv_err = (s_mode && pte_i.u && !sum_i) || (!s_mode && !pte_i.u);

    // stores also need a writable and dirty page
    assign fault = is_store_i ? (!pte_i.w || !pte_i.d || priv_err) : priv_err;

    // ------------------------------------------------------------------
    // address composition and response
    // ------------------------------------------------------------------

    always_comb begin : compose
        paddr_o     = '0;
        miss_o      = 1'b0;
        exc_valid_o = 1'b0;
        exc_cause_o = exc_cause_t'(6'd0);
        exc_tval_o  = '0;
        if (valid_i) begin
            if (!en_translation_i) begin
                // bare mode
                paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_i.flat};
            end else begin
                // 4K page by default
                paddr_o = {pte_i.ppn, vaddr_i.f.offset};
                // mega page keeps vpn0 from the virtual address
                if (is_2m_i || is_1g_i) begin
                    paddr_o[`MMU_OFFSET_W +: 9] = vaddr_i.f.vpn0;
                end
                // giga page keeps vpn1 as well
                if (is_1g_i) begin
                    paddr_o[`MMU_OFFSET_W + 9 +: 9] = vaddr_i.f.vpn1;
                end
                if (!hit_i) begin
                    // requester refills and retries
                    miss_o = 1'b1;
                end else if (fault) begin
                    exc_valid_o = 1'b1;
                    exc_cause_o = is_store_i ? CAUSE_STORE_PAGE_FAULT : CAUSE_LOAD_PAGE_FAULT;
                    exc_tval_o  = {{(`MMU_XLEN - `MMU_VLEN){vaddr_i.flat[`MMU_VLEN-1]}},
                                   vaddr_i.flat};
                end
            end
        end
    end

endmodule

// ==== source/lookup_stage_reg.sv ====
`timescale 1ns/1ps

module lookup_stage_reg (
    input  logic                clk_i,
    input  logic                rst_ni,
    // handshake
    input  logic                in_valid_i,
    output logic                in_ready_o,
    output logic                out_valid_o,
    input  logic                out_ready_i,
    // request and tlb answer
    input  mmu_pkg::vaddr_t     vaddr_i,
    input  logic                is_store_i,
    input  logic                hit_i,
    input  mmu_pkg::pte_t       pte_i,
    input  logic                is_2m_i,
    input  logic                is_1g_i,
    input  logic                en_translation_i,
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    // registered copies
    output mmu_pkg::vaddr_t     vaddr_o,
    output logic                is_store_o,
    output logic                hit_o,
    output mmu_pkg::pte_t       pte_o,
    output logic                is_2m_o,
    output logic                is_1g_o,
    output logic                en_translation_o,
    output mmu_pkg::priv_lvl_t  priv_lvl_o,
    output logic                sum_o
);
    import mmu_pkg::*;

    logic       valid_q;
    logic       accept;
    vaddr_t     vaddr_q;
    pte_t       pte_q;
    priv_lvl_t  priv_lvl_q;
    logic [5:0] flags_q;

    // slot free or being drained this cycle
    assign in_ready_o  = !valid_q || out_ready_i;
    assign accept      = in_valid_i && in_ready_o;
    assign out_valid_o = valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_reg
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    // payload only loads on accept and holds under back-pressure
    always_ff @(posedge clk_i) begin : payload_reg
        if (accept) begin
            vaddr_q    <= vaddr_i;
            pte_q      <= pte_i;
            priv_lvl_q <= priv_lvl_i;
            flags_q    <= {is_store_i, hit_i, is_2m_i, is_1g_i, en_translation_i, sum_i};
        end
    end

    assign vaddr_o          = vaddr_q;
    assign pte_o            = pte_q;
    assign priv_lvl_o       = priv_lvl_q;
    assign is_store_o       = flags_q[5];
    assign hit_o            = flags_q[4];
    assign is_2m_o          = flags_q[3];
    assign is_1g_o          = flags_q[2];
    assign en_translation_o = flags_q[1];
    assign sum_o            = flags_q[0];

endmodule

// ==== source/dtlb.sv ====
`timescale 1ns/1ps
`include "mmu_settings.svh"

module dtlb #(
    parameter int unsigned NumEntries = `MMU_TLB_ENTRIES
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    // lookup port
    input  mmu_pkg::vaddr_t         lu_vaddr_i,
    input  logic [`MMU_ASIDW-1:0]   lu_asid_i,
    output logic                    lu_hit_o,
    output mmu_pkg::pte_t           lu_pte_o,
    output logic                    lu_is_2m_o,
    output logic                    lu_is_1g_o,
    // refill port
    input  logic                    upd_valid_i,
    input  mmu_pkg::vaddr_t         upd_vaddr_i,
    input  logic [`MMU_ASIDW-1:0]   upd_asid_i,
    input  logic                    upd_is_2m_i,
    input  logic                    upd_is_1g_i,
    input  mmu_pkg::pte_t           upd_pte_i,
    // flush port
    input  logic                    flush_i,
    input  logic [`MMU_ASIDW-1:0]   flush_asid_i,
    input  mmu_pkg::vaddr_t         flush_vaddr_i
);
    import mmu_pkg::*;

    localparam int unsigned IdxW = $clog2(NumEntries);

    // entry state
    logic [NumEntries-1:0]  valid_q;
    vaddr_t                 tag_q   [NumEntries];
    logic [`MMU_ASIDW-1:0]  asid_q  [NumEntries];
    pte_t                   pte_q   [NumEntries];
    logic [NumEntries-1:0]  is_2m_q;
    logic [NumEntries-1:0]  is_1g_q;

    // round-robin victim pointer
    logic [IdxW-1:0]        rr_q;
    logic [IdxW-1:0]        rr_next;

    logic [NumEntries-1:0]  lu_match;
    logic [NumEntries-1:0]  flush_hit;
    logic                   flush_asid_zero;
    logic                   flush_addr_zero;

    // vpn compare, upper levels only for super pages
    function automatic logic vpn_match(vaddr_t tag, vaddr_t va, logic is_2m, logic is_1g);
        logic m2;
        logic m1;
        logic m0;
        m2 = (tag.f.vpn2 == va.f.vpn2);
        m1 = (tag.f.vpn1 == va.f.vpn1);
        m0 = (tag.f.vpn0 == va.f.vpn0);
        return m2 && (m1 || is_1g) && (m0 || is_2m || is_1g);
    endfunction

    // ------------------------------------------------------------------
    // match logic
    // ------------------------------------------------------------------

    assign flush_asid_zero = (flush_asid_i == '0);
    assign flush_addr_zero = (flush_vaddr_i.flat == '0);

    always_comb begin : match_logic
        for (int unsigned i = 0; i < NumEntries; i++) begin
            // global pages hit under any asid
            lu_match[i] = valid_q[i] && (pte_q[i].g || asid_q[i] == lu_asid_i) &&
                          vpn_match(tag_q[i], lu_vaddr_i, is_2m_q[i], is_1g_q[i]);
            // asid specific flush spares global pages
            if (flush_asid_zero) begin
                flush_hit[i] = flush_addr_zero ||
                               vpn_match(tag_q[i], flush_vaddr_i, is_2m_q[i], is_1g_q[i]);
            end else begin
                flush_hit[i] = !pte_q[i].g && (asid_q[i] == flush_asid_i) &&
                               (flush_addr_zero ||
                                vpn_match(tag_q[i], flush_vaddr_i, is_2m_q[i], is_1g_q[i]));
            end
        end
    end

    // at most one entry matches, so a plain select is enough
    always_comb begin : lookup_mux
        lu_hit_o   = 1'b0;
        lu_pte_o   = '0;
        lu_is_2m_o = 1'b0;
        lu_is_1g_o = 1'b0;
        for (int unsigned i = 0; i < NumEntries; i++) begin
            if (lu_match[i]) begin
                lu_hit_o   = 1'b1;
                lu_pte_o   = pte_q[i];
                lu_is_2m_o = is_2m_q[i];
                lu_is_1g_o = is_1g_q[i];
            end
        end
    end

    // ------------------------------------------------------------------
    // refill and flush
    // ------------------------------------------------------------------

    // wrap for depths that are not a power of two
    assign rr_next = (rr_q == IdxW'(NumEntries - 1)) ? '0 : rr_q + 1'b1;

    // flush wins over a refill in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            valid_q <= valid_q & ~flush_hit;
        end else if (upd_valid_i) begin
            valid_q[rr_q] <= 1'b1;
            rr_q          <= rr_next;
        end
    end

    always_ff @(posedge clk_i) begin : entry_regs
        if (upd_valid_i && !flush_i) begin
            tag_q[rr_q]   <= upd_vaddr_i;
            asid_q[rr_q]  <= upd_asid_i;
            pte_q[rr_q]   <= upd_pte_i;
            is_2m_q[rr_q] <= upd_is_2m_i;
            is_1g_q[rr_q] <= upd_is_1g_i;
        end
    end

endmodule

// ==== source/mmu_pkg.sv ====
`include "mmu_settings.svh"

package mmu_pkg;

    // ------------------------------------------------------------------
    // virtual address
    // ------------------------------------------------------------------

    // three 9 bit vpn levels above the page offset
    typedef struct packed {
        logic [8:0]                 vpn2;
        logic [8:0]                 vpn1;
        logic [8:0]                 vpn0;
        logic [`MMU_OFFSET_W-1:0]   offset;
    } vaddr_fields_t;

    // flat view for pass-through and tval, field view for tag match
    typedef union packed {
        logic [`MMU_VLEN-1:0]   flat;
        vaddr_fields_t          f;
    } vaddr_t;

    // ------------------------------------------------------------------
    // page table entry
    // ------------------------------------------------------------------

    typedef struct packed {
        logic [`MMU_PPNW-1:0]   ppn;
        logic                   d;
        logic                   a;
        logic                   g;
        logic                   u;
        logic                   x;
        logic                   w;
        logic                   r;
        logic                   v;
    } pte_t;

    // M mode accesses are handled like S mode
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_lvl_t;

    // mcause encodings of the two page faults
    typedef enum logic [5:0] {
        CAUSE_LOAD_PAGE_FAULT  = 6'd13,
        CAUSE_STORE_PAGE_FAULT = 6'd15
    } exc_cause_t;

endpackage

// ==== source/mmu_settings.svh ====
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// sv39 virtual address width
`define MMU_VLEN 39
// physical address width
`define MMU_PLEN 56
// physical page number width
`define MMU_PPNW 44
// address space identifier width
`define MMU_ASIDW 9
// exception value width
`define MMU_XLEN 64
// page offset width for 4K pages
`define MMU_OFFSET_W 12

// default number of data TLB entries
`define MMU_TLB_ENTRIES 4

`endif
